// ==== src/soc_consts.svh ====
// soc constants: ram depth, io page bit, io register select bits, uart bit period
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ram size in 32-bit words
`define SOC_RAM_WORDS 1024

// address bit that selects the io page
`define SOC_IO_PAGE_BIT 22

// one-hot io register selects, bit positions in the io word address
`define SOC_IO_LEDS_BIT      0   // rw, 4 leds
`define SOC_IO_UART_CNTL_BIT 4   // r, tx busy (bit 9) and rx valid (bit 8)
`define SOC_IO_UART_DAT_BIT  5   // r received byte, w byte to send
`define SOC_IO_BUTTONS_BIT   10  // r, 6 buttons

// uart bit period in clocks, short for simulation
`define SOC_UART_CLKS_PER_BIT 8

`endif

// ==== src/soc_bus_pkg.sv ====
// processor-side bus types: address union with ram and io views, bus request struct
`default_nettype none

package soc_bus_pkg;

  // ram view of the 24-bit address
  typedef struct packed {
    logic        spare;      // bit 23, reserved page
    logic        io_page;    // bit 22
    logic [19:0] word_addr;  // bits 21..2
    logic [1:0]  byte_off;
  } addr_ram_t;

  // io view of the same address
  typedef struct packed {
    logic        spare;      // bit 23, counts as padding
    logic        io_page;    // bit 22
    logic [8:0]  pad;        // bits 21..13
    logic [10:0] io_sel;     // one-hot register select, bits 12..2
    logic [1:0]  byte_off;
  } addr_io_t;

  typedef union packed {
    addr_ram_t ram;
    addr_io_t  io;
  } soc_addr_u;

  // one request per cycle, rd or nonzero wmask
  typedef struct packed {
    soc_addr_u   addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;  // byte lanes, nonzero means write
    logic        rd;     // read strobe
  } bus_req_t;

endpackage

`default_nettype wire

// ==== src/soc_io_pkg.sv ====
// io side types: io request struct, uart status word
`default_nettype none

package soc_io_pkg;

  // request as seen by the io block
  typedef struct packed {
    logic [10:0] sel;    // one-hot register select
    logic        wr;
    logic        rd;
    logic [31:0] wdata;
  } io_req_t;

  // uart control register, read only
  typedef struct packed {
    logic [21:0] pad_hi;
    logic        tx_busy;   // bit 9
    logic        rx_valid;  // bit 8
    logic [7:0]  pad_lo;
  } uart_status_t;

endpackage

`default_nettype wire

// ==== src/uart_tx.sv ====
// uart transmitter, 8n1, with busy flag
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module uart_tx (
  input  wire       clk,
  input  wire       RESET,
  input  wire       start,
  input  wire [7:0] data,
  output logic      busy,
  output wire       txd
);

  localparam int CLK_W = $clog2(`SOC_UART_CLKS_PER_BIT);

  logic [CLK_W-1:0] clk_cnt;   // position inside the bit period
  logic [3:0]       bit_cnt;   // 10 bits per frame
  logic [9:0]       shreg;     // stop, data, start; lsb on the line

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      busy    <= 1'b0;
      shreg   <= '1;          // line idles high
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        shreg   <= {1'b1, data, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == CLK_W'(`SOC_UART_CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      shreg   <= {1'b1, shreg[9:1]};  // fill with idle level
      if (bit_cnt == 4'd9)
        busy <= 1'b0;                 // stop bit done
      else
        bit_cnt <= bit_cnt + 4'd1;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign txd = shreg[0];

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
// uart receiver, 8n1, one-cycle valid pulse with the byte
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module uart_rx (
  input  wire        clk,
  input  wire        RESET,
  input  wire        rxd,
  output logic       valid,
  output wire  [7:0] data
);

  localparam int CLK_W = $clog2(`SOC_UART_CLKS_PER_BIT);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

  state_t           state;
  logic             rxd_s1;
  logic             rxd_s2;   // synchronized line
  logic             rxd_q;    // previous value, for the edge
  logic [CLK_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shreg;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rxd_s1 <= 1'b1;
      rxd_s2 <= 1'b1;
      rxd_q  <= 1'b1;
    end else begin
      rxd_s1 <= rxd;
      rxd_s2 <= rxd_s1;
      rxd_q  <= rxd_s2;
    end
  end

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      state   <= IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      valid   <= 1'b0;
    end else begin
      valid <= 1'b0;  // pulse only
      case (state)
        IDLE: begin
          if (rxd_q && !rxd_s2) begin   // falling edge, start bit
            state   <= START;
            clk_cnt <= '0;
          end
        end
        START: begin
          if (clk_cnt == CLK_W'(`SOC_UART_CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rxd_s2 ? IDLE : DATA;  // glitch, back to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        DATA: begin
          if (clk_cnt == CLK_W'(`SOC_UART_CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 3'd7)
              state <= STOP;
            bit_cnt <= bit_cnt + 3'd1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin  // STOP
          if (clk_cnt == CLK_W'(`SOC_UART_CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            valid   <= rxd_s2;   // bad stop bit drops the frame
            state   <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // mid-bit samples, lsb first
  always_ff @(posedge clk) begin
    if (state == DATA && clk_cnt == CLK_W'(`SOC_UART_CLKS_PER_BIT - 1))
      shreg <= {rxd_s2, shreg[7:1]};
  end

  assign data = shreg;

endmodule

`default_nettype wire

// ==== src/soc_io_block.sv ====
// io block: one-hot decode, led register, uart rx latch, buttons, read or-mux
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_io_block (
  input  wire                  clk,
  input  wire                  RESET,
  input  soc_io_pkg::io_req_t  io_req,
  input  wire                  rxd,
  input  wire [5:0]            buttons,
  output logic [31:0]          io_rdata,
  output wire                  wbusy,
  output wire                  txd,
  output logic [3:0]           leds
);

  logic                     sel_leds;
  logic                     sel_cntl;
  logic                     sel_dat;
  logic                     sel_btn;
  logic                     tx_start;
  logic                     tx_busy;
  logic                     rx_pulse;
  logic [7:0]               rx_byte;
  logic [7:0]               rx_byte_q;   // byte kept until the next frame
  logic                     rx_valid_q;
  soc_io_pkg::uart_status_t status;

  // one bit per register
  assign sel_leds = io_req.sel[`SOC_IO_LEDS_BIT];
  assign sel_cntl = io_req.sel[`SOC_IO_UART_CNTL_BIT];
  assign sel_dat  = io_req.sel[`SOC_IO_UART_DAT_BIT];
  assign sel_btn  = io_req.sel[`SOC_IO_BUTTONS_BIT];

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= '0;
    end else if (io_req.wr && sel_leds) begin
      leds <= io_req.wdata[3:0];
    end
  end

  assign tx_start = io_req.wr && sel_dat;  // ignored by tx while busy

  uart_tx u_uart_tx (
    .clk   (clk),
    .RESET (RESET),
    .start (tx_start),
    .data  (io_req.wdata[7:0]),
    .busy  (tx_busy),
    .txd   (txd)
  );

  uart_rx u_uart_rx (
    .clk   (clk),
    .RESET (RESET),
    .rxd   (rxd),
    .valid (rx_pulse),
    .data  (rx_byte)
  );

  always_ff @(posedge clk) begin
    if (rx_pulse)
      rx_byte_q <= rx_byte;
  end

  // valid flag; a data read in the same cycle as a new byte clears it
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rx_valid_q <= 1'b0;
    end else begin
      if (rx_pulse)
        rx_valid_q <= 1'b1;
      if (io_req.rd && sel_dat)
        rx_valid_q <= 1'b0;  // read wins
    end
  end

  always_comb begin
    status          = '0;
    status.tx_busy  = tx_busy;
    status.rx_valid = rx_valid_q;
  end

  // or of all selected sources
  always_comb begin
    io_rdata = '0;
    if (sel_leds) io_rdata |= {28'b0, leds};
    if (sel_cntl) io_rdata |= status;
    if (sel_dat)  io_rdata |= {24'b0, rx_byte_q};
    if (sel_btn)  io_rdata |= {26'b0, buttons};
  end

  assign wbusy = tx_busy;

endmodule

`default_nettype wire

// ==== src/soc_mem_interface.sv ====
// memory interface: byte-masked ram, io page routing, registered read data
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_mem_interface (
  input  wire                    clk,
  input  wire                    RESET,
  input  soc_bus_pkg::bus_req_t  bus_req,
  input  wire [31:0]             io_rdata,
  input  wire                    io_wbusy,
  output logic [31:0]            rdata,
  output wire                    wbusy,
  output soc_io_pkg::io_req_t    io_req
);

  localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);

  logic [31:0]       ram [`SOC_RAM_WORDS];
  logic              is_io;
  logic              wr;
  logic [RAM_AW-1:0] ram_idx;

  assign is_io   = bus_req.addr[`SOC_IO_PAGE_BIT];
  assign wr      = |bus_req.wmask;
  assign ram_idx = bus_req.addr.ram.word_addr[RAM_AW-1:0];  // upper word bits ignored

  // ram writes, one lane per mask bit
  always_ff @(posedge clk) begin
    if (wr && !is_io) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus_req.wmask[lane])
          ram[ram_idx][lane*8 +: 8] <= bus_req.wdata[lane*8 +: 8];
      end
    end
  end

  // io page forwarded in the same cycle
  always_comb begin
    io_req.sel   = bus_req.addr.io.io_sel;
    io_req.wr    = wr && is_io;
    io_req.rd    = bus_req.rd && is_io;
    io_req.wdata = bus_req.wdata;
  end

  // read data, loaded at the end of the strobe cycle and held until the next read
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rdata <= '0;
    end else if (bus_req.rd) begin
      rdata <= is_io ? io_rdata : ram[ram_idx];
    end
  end

  assign wbusy = io_wbusy;  // only the uart tx can stall writes

endmodule

`default_nettype wire

// ==== src/soc_top.sv ====
// soc top: memory interface and io block
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  wire                    clk,
  input  wire                    RESET,
  input  soc_bus_pkg::bus_req_t  bus_req,
  input  wire                    rxd,
  input  wire [5:0]              buttons,
  output wire [31:0]             rdata,
  output wire                    wbusy,
  output wire                    txd,
  output wire [3:0]              leds
);

  soc_io_pkg::io_req_t io_req;     // memory interface to io block
  wire [31:0]          io_rdata;
  wire                 io_wbusy;

  soc_mem_interface u_mem (
    .clk      (clk),
    .RESET    (RESET),
    .bus_req  (bus_req),
    .io_rdata (io_rdata),
    .io_wbusy (io_wbusy),
    .rdata    (rdata),
    .wbusy    (wbusy),
    .io_req   (io_req)
  );

  soc_io_block u_io (
    .clk      (clk),
    .RESET    (RESET),
    .io_req   (io_req),
    .rxd      (rxd),
    .buttons  (buttons),
    .io_rdata (io_rdata),
    .wbusy    (io_wbusy),
    .txd      (txd),
    .leds     (leds)
  );

endmodule

`default_nettype wire

// ==== tests/tb_soc_top.sv ====
// testbench for soc_top: bus master tasks, ram shadow model, uart loopback, checks
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module tb_soc_top;

  localparam int FRAME_CYC = 10 * `SOC_UART_CLKS_PER_BIT;  // start, 8 data, stop
  localparam int POLL_MAX  = FRAME_CYC / 2;                 // status polls per byte
  localparam int RAM_OPS   = 300;
  // two cycles per bus op plus each frame with its poll bound, then doubled for margin
  localparam int LIMIT_CYC = 2 * (RAM_OPS * 2 + 4 * (FRAME_CYC + 2 * POLL_MAX + 8) + 200);

  logic                  clk;
  logic                  RESET;
  soc_bus_pkg::bus_req_t bus_req;
  logic [5:0]            buttons;
  wire  [31:0]           rdata;
  wire                   wbusy;
  wire                   txd;
  wire  [3:0]            leds;

  logic [31:0] shadow [`SOC_RAM_WORDS];  // ram reference model
  int          pool [$];                 // word indices with known contents
  integer      seed;
  int          errors;
  int          errors_at_start;          // error count when the current test began
  int          pass_cnt;
  int          fail_cnt;

  soc_top u_dut (
    .clk     (clk),
    .RESET   (RESET),
    .bus_req (bus_req),
    .rxd     (txd),      // serial loopback
    .buttons (buttons),
    .rdata   (rdata),
    .wbusy   (wbusy),
    .txd     (txd),
    .leds    (leds)
  );

  always #2 clk = ~clk;  // 4 ns period

  // line idles high outside a frame
  assert property (@(posedge clk) disable iff (!RESET) !wbusy |-> txd)
    else begin
      $display("** Error @ %0t ns: txd low while wbusy is low", $time);
      errors++;
    end

  function automatic soc_bus_pkg::soc_addr_u ram_addr(input int idx);
    soc_bus_pkg::soc_addr_u a;
    a = '0;
    a.ram.word_addr = 20'(idx);
    return a;
  endfunction

  function automatic soc_bus_pkg::soc_addr_u io_addr(input int sel_bit);
    soc_bus_pkg::soc_addr_u a;
    a = '0;
    a.io.io_page         = 1'b1;
    a.io.io_sel[sel_bit] = 1'b1;  // one-hot register select
    return a;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
    else begin
      $display("** Error @ %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_missing(input string what);
    $display("%s", what);
    errors++;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // one strobe cycle driven 1 ns after the edge
  // returns 1 ns after the ending edge
  task automatic issue(input soc_bus_pkg::bus_req_t req);
    @(posedge clk);
    #1;
    bus_req = req;
    @(posedge clk);
    #1;
    bus_req = '0;
  endtask

  task automatic bus_write(input soc_bus_pkg::soc_addr_u addr, input logic [31:0] data,
                           input logic [3:0] mask);
    soc_bus_pkg::bus_req_t req;
    req       = '0;
    req.addr  = addr;
    req.wdata = data;
    req.wmask = mask;
    issue(req);
  endtask

  task automatic bus_read(input soc_bus_pkg::soc_addr_u addr, output logic [31:0] data);
    soc_bus_pkg::bus_req_t req;
    req      = '0;
    req.addr = addr;
    req.rd   = 1'b1;
    issue(req);
    data = rdata;  // loaded on the edge that ended the strobe
  endtask

  // ram write plus the same merge in the shadow
  task automatic ram_write_tracked(input int idx, input logic [31:0] data,
                                   input logic [3:0] mask);
    bus_write(ram_addr(idx), data, mask);
    for (int lane = 0; lane < 4; lane++) begin
      if (mask[lane])
        shadow[idx][lane*8 +: 8] = data[lane*8 +: 8];
    end
  endtask

  task automatic check_idle_outputs(input string when);
    check_eq(wbusy, 1'b0, {"wbusy ", when});
    check_eq(txd, 1'b1, {"txd ", when});
    check_eq(leds, 4'h0, {"leds ", when});
  endtask

  // wait out the frame, poll for the byte, read it, confirm the flag cleared
  task automatic receive_byte(input logic [7:0] expected);
    soc_io_pkg::uart_status_t status;
    logic [31:0]              data;
    int                       polls;
    int                       waited;
    polls  = 0;
    waited = 0;
    status = '0;
    data   = '0;
    while (wbusy && waited <= FRAME_CYC) begin  // no requests while tx busy
      waited++;
      @(posedge clk);
      #1;
    end
    if (wbusy) begin
      report_missing("uart transmitter never went idle");
    end else begin
      while (!status.rx_valid && polls < POLL_MAX) begin
        bus_read(io_addr(`SOC_IO_UART_CNTL_BIT), data);
        status = soc_io_pkg::uart_status_t'(data);
        polls++;
      end
      if (!status.rx_valid) begin
        report_missing("uart byte never received");
      end else begin
        check_eq(data & ~32'h300, 32'h0, "uart status padding");
        bus_read(io_addr(`SOC_IO_UART_DAT_BIT), data);
        check_eq(data, {24'h0, expected}, "uart received byte");
        bus_read(io_addr(`SOC_IO_UART_CNTL_BIT), data);
        status = soc_io_pkg::uart_status_t'(data);
        check_eq(status.rx_valid, 1'b0, "rx_valid after data read");
      end
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic [7:0]  tx_byte;
    logic [5:0]  btn;
    int          idx;
    int          busy_cycles;
    clk             = 1'b0;
    RESET           = 1'b0;
    bus_req         = '0;
    buttons         = '0;
    seed            = 90045;
    errors          = 0;
    errors_at_start = 0;
    pass_cnt        = 0;
    fail_cnt        = 0;

    // reset state
    repeat (5) begin
      @(posedge clk);
      #1;
      check_idle_outputs("during reset");
    end
    RESET = 1'b1;
    @(posedge clk);
    #1;
    check_idle_outputs("after reset");
    bus_read(io_addr(`SOC_IO_UART_CNTL_BIT), data);
    check_eq(data, 32'h0, "uart status after reset");
    finish_test("reset_state");

    // byte-masked ram writes
    // full-word fill first so every lane is known
    repeat (32) begin
      idx = $unsigned($random(seed)) % `SOC_RAM_WORDS;
      ram_write_tracked(idx, $random(seed), 4'hF);
      pool.push_back(idx);
    end
    repeat (100) begin
      idx  = pool[$unsigned($random(seed)) % pool.size()];
      mask = 4'($random(seed));
      if (mask == 4'h0)
        mask = 4'hF;
      ram_write_tracked(idx, $random(seed), mask);
      idx = pool[$unsigned($random(seed)) % pool.size()];
      bus_read(ram_addr(idx), data);
      check_eq(data, shadow[idx], "ram read vs shadow");
    end
    finish_test("ram_byte_mask");

    // led register
    // ram word 1 shares the word address of the led select
    ram_write_tracked(1, $random(seed), 4'hF);
    wdata = $random(seed);
    bus_write(io_addr(`SOC_IO_LEDS_BIT), wdata, 4'hF);
    check_eq(leds, wdata[3:0], "leds after write");
    bus_read(io_addr(`SOC_IO_LEDS_BIT), data);
    check_eq(data, {28'h0, wdata[3:0]}, "led readback");
    bus_read(ram_addr(1), data);
    check_eq(data, shadow[1], "ram word 1 after io write");
    finish_test("io_page_leds");

    // buttons
    repeat (4) begin
      @(posedge clk);
      #1;
      btn     = 6'($random(seed));
      buttons = btn;
      bus_read(io_addr(`SOC_IO_BUTTONS_BIT), data);
      check_eq(data, {26'h0, btn}, "buttons read");
    end
    finish_test("buttons");

    // tx busy length and start bit then drain the looped byte
    tx_byte = 8'($random(seed));
    bus_write(io_addr(`SOC_IO_UART_DAT_BIT), {24'h0, tx_byte}, 4'h1);
    check_eq(wbusy, 1'b1, "wbusy after uart write");
    busy_cycles = 0;
    while (wbusy && busy_cycles <= FRAME_CYC) begin
      if (busy_cycles < `SOC_UART_CLKS_PER_BIT)
        check_eq(txd, 1'b0, "txd in start bit");
      busy_cycles++;
      @(posedge clk);
      #1;
    end
    check_eq(busy_cycles, FRAME_CYC, "wbusy high cycles");
    receive_byte(tx_byte);
    finish_test("uart_tx_busy");

    // loopback of random bytes
    repeat (3) begin
      tx_byte = 8'($random(seed));
      bus_write(io_addr(`SOC_IO_UART_DAT_BIT), {24'h0, tx_byte}, 4'h1);
      receive_byte(tx_byte);
    end
    finish_test("uart_loopback");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog with a limit from ram ops and uart frames
  initial begin
    #(LIMIT_CYC * 4);
    $display("watchdog: run went past %0d cycles, a test is stuck", LIMIT_CYC);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/soc_bus_pkg.sv
src/soc_io_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/soc_io_block.sv
src/soc_mem_interface.sv
src/soc_top.sv
tests/tb_soc_top.sv

// ==== Bender.yml ====
package:
  name: soc_mem_io

export_include_dirs:
  - src

sources:
  - files:
      - src/soc_bus_pkg.sv
      - src/soc_io_pkg.sv
      - src/uart_tx.sv
      - src/uart_rx.sv
      - src/soc_io_block.sv
      - src/soc_mem_interface.sv
      - src/soc_top.sv
  - target: test
    files:
      - tests/tb_soc_top.sv
